// ==== source/audio_pkg.sv ====
package audio_pkg;

  // sample format
  localparam int sample_w = 16;

  // i2s timebase, one frame is 2048 audio_clk cycles
  localparam int phase_w   = 11;
  localparam int bclk_bit  = 4;   // bit clock period of 32 cycles
  localparam int lrclk_bit = 10;  // word clock, low for the left half

  // last cycle of the left half, sample complete here
  localparam logic [phase_w-1:0] capture_phase = (1 << lrclk_bit) - 1;

  // dc blocker leak
  localparam int dc_shift = 8;

  // echo delay line
  localparam int delay_depth = 256;
  localparam int delay_ptr_w = $clog2(delay_depth);
  localparam int delay_sel_w = 6;
  localparam logic [delay_ptr_w-1:0] delay_step = 4;  // frames per selector step

  // source select codes
  localparam logic [1:0] src_raw  = 2'd0;
  localparam logic [1:0] src_dc   = 2'd1;
  localparam logic [1:0] src_echo = 2'd2;
  localparam logic [1:0] src_mute = 2'd3;

endpackage

// ==== source/i2s_mic_rx.sv ====
`timescale 1ns/1ps

module i2s_mic_rx (
  input  logic                          audio_clk,
  input  logic                          rst_n,
  input  logic                          mic_data,
  output logic                          mic_bclk,
  output logic                          mic_lrclk,
  output logic [audio_pkg::sample_w-1:0] raw_sample,
  output logic                          raw_valid
);
  import audio_pkg::*;

  logic [phase_w-1:0]            phase;      // free running frame position
  logic [lrclk_bit-bclk_bit-2:0] slot;       // bit slot within the half frame
  logic                          bclk_rise;
  logic                          left_half;
  logic                          keep_bit;
  logic [sample_w-1:0]           shift_reg;

  // slot number is just the upper part of the phase
  assign slot      = phase[lrclk_bit-1:bclk_bit+1];
  assign left_half = ~phase[lrclk_bit];

  // cycle where the bit clock bit goes 0 -> 1
  assign bclk_rise = phase[bclk_bit] && (phase[bclk_bit-1:0] == '0);

  // msb sits in slot 1 after the empty slot 0
  assign keep_bit = bclk_rise && left_half && (slot != '0) && (slot <= sample_w);

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      phase     <= '0;
      mic_bclk  <= 1'b0;
      mic_lrclk <= 1'b0;
    end else begin
      phase     <= phase + 1'b1;
      mic_bclk  <= phase[bclk_bit];   // registered onto the pins
      mic_lrclk <= phase[lrclk_bit];
    end
  end

  // msb first into the shift register
  always_ff @(posedge audio_clk) begin
    if (keep_bit) begin
      shift_reg <= {shift_reg[sample_w-2:0], mic_data};
    end
  end

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      raw_sample <= '0;
      raw_valid  <= 1'b0;
    end else begin
      raw_valid <= (phase == capture_phase);
      if (phase == capture_phase) begin
        raw_sample <= shift_reg;  // held until next frame
      end
    end
  end

endmodule

// ==== source/dc_blocker.sv ====
`timescale 1ns/1ps

module dc_blocker (
  input  logic                                 audio_clk,
  input  logic                                 rst_n,
  input  logic signed [audio_pkg::sample_w-1:0] in_sample,
  input  logic                                 in_valid,
  output logic signed [audio_pkg::sample_w-1:0] out_sample,
  output logic                                 out_valid
);
  import audio_pkg::*;

  logic signed [sample_w-1:0] prev_in;
  logic signed [sample_w+1:0] acc;   // two guard bits
  logic signed [sample_w-1:0] sat;

  // y = x - x_prev + y_prev - (y_prev >>> shift)
  // out_sample doubles as the previous output
  always_comb begin
    acc = in_sample - prev_in + out_sample - (out_sample >>> dc_shift);
    if ((acc[sample_w+1:sample_w-1] == '0) || (acc[sample_w+1:sample_w-1] == '1)) begin
      sat = acc[sample_w-1:0];
    end else if (acc[sample_w+1]) begin
      sat = {1'b1, {(sample_w-1){1'b0}}};  // clip negative
    end else begin
      sat = {1'b0, {(sample_w-1){1'b1}}};  // clip positive
    end
  end

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      prev_in    <= '0;
      out_sample <= '0;
      out_valid  <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        prev_in    <= in_sample;
        out_sample <= sat;
      end
    end
  end

endmodule

// ==== source/echo_delay.sv ====
`timescale 1ns/1ps

module echo_delay (
  input  logic                                 audio_clk,
  input  logic                                 rst_n,
  input  logic [audio_pkg::delay_sel_w-1:0]     delay_sel,
  input  logic signed [audio_pkg::sample_w-1:0] in_sample,
  input  logic                                 in_valid,
  output logic signed [audio_pkg::sample_w-1:0] out_sample,
  output logic                                 out_valid
);
  import audio_pkg::*;

  logic signed [sample_w-1:0] mem [delay_depth];
  logic [delay_ptr_w-1:0]     wr_ptr;
  logic [delay_ptr_w-1:0]     rd_ptr;
  logic [delay_ptr_w-1:0]     delay;
  logic [delay_ptr_w-1:0]     fill;   // writes since reset, saturating

  assign delay  = delay_sel * delay_step;  // in frames
  assign rd_ptr = wr_ptr - delay;           // wraps around the ring

  // sample ring
  always_ff @(posedge audio_clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_sample;
    end
  end

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      fill   <= '0;
    end else if (in_valid) begin
      wr_ptr <= wr_ptr + 1'b1;
      if (fill != '1) begin
        fill <= fill + 1'b1;
      end
    end
  end

  // read side, registered with out_valid
  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      out_sample <= '0;
      out_valid  <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        if (delay == '0) begin
          out_sample <= in_sample;   // zero delay passes straight on
        end else if (fill < delay) begin
          out_sample <= '0;          // not enough history yet
        end else begin
          out_sample <= mem[rd_ptr];
        end
      end
    end
  end

endmodule

// ==== source/pdm_modulator.sv ====
`timescale 1ns/1ps

module pdm_modulator (
  input  logic                                 audio_clk,
  input  logic                                 rst_n,
  input  logic signed [audio_pkg::sample_w-1:0] level,
  output logic                                 pdm_out
);
  import audio_pkg::*;

  logic [sample_w-1:0] offset;  // offset binary level
  logic [sample_w-1:0] acc;
  logic [sample_w:0]   sum;     // extra bit is the carry

  assign offset = {~level[sample_w-1], level[sample_w-2:0]};
  assign sum    = acc + offset;

  // first order sigma-delta, carry is the output bit
  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      acc     <= '0;
      pdm_out <= 1'b0;
    end else begin
      acc     <= sum[sample_w-1:0];
      pdm_out <= sum[sample_w];
    end
  end

endmodule

// ==== source/audio_top.sv ====
`timescale 1ns/1ps

module audio_top (
  input  logic                              audio_clk,
  input  logic                              rst_n,
  input  logic                              mic_data,
  output logic                              mic_bclk,
  output logic                              mic_lrclk,
  input  logic [1:0]                        source_sel,
  input  logic [audio_pkg::delay_sel_w-1:0] delay_sel,
  input  logic [1:0]                        spk_en,
  output logic                              spk_left,
  output logic                              spk_right,
  output logic [audio_pkg::sample_w-1:0]    monitor_sample,
  output logic                              sample_strobe
);
  import audio_pkg::*;

  logic [sample_w-1:0]        raw_sample;
  logic                       raw_valid;
  logic signed [sample_w-1:0] dc_sample;
  logic                       dc_valid;
  logic signed [sample_w-1:0] echo_sample;
  logic                       echo_valid;
  logic                       pdm_out;

  i2s_mic_rx u_rx (
    .audio_clk  (audio_clk),
    .rst_n      (rst_n),
    .mic_data   (mic_data),
    .mic_bclk   (mic_bclk),
    .mic_lrclk  (mic_lrclk),
    .raw_sample (raw_sample),
    .raw_valid  (raw_valid)
  );

  dc_blocker u_dc (
    .audio_clk  (audio_clk),
    .rst_n      (rst_n),
    .in_sample  (raw_sample),
    .in_valid   (raw_valid),
    .out_sample (dc_sample),
    .out_valid  (dc_valid)
  );

  echo_delay u_echo (
    .audio_clk  (audio_clk),
    .rst_n      (rst_n),
    .delay_sel  (delay_sel),
    .in_sample  (dc_sample),
    .in_valid   (dc_valid),
    .out_sample (echo_sample),
    .out_valid  (echo_valid)
  );

  // all sources sampled together at the end of the chain
  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      monitor_sample <= '0;
      sample_strobe  <= 1'b0;
    end else begin
      sample_strobe <= echo_valid;
      if (echo_valid) begin
        case (source_sel)
          src_raw:  monitor_sample <= raw_sample;
          src_dc:   monitor_sample <= dc_sample;
          src_echo: monitor_sample <= echo_sample;
          src_mute: monitor_sample <= '0;
          default:  monitor_sample <= '0;
        endcase
      end
    end
  end

  // monitor word is also the speaker level
  pdm_modulator u_pdm (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .level     (monitor_sample),
    .pdm_out   (pdm_out)
  );

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      spk_left  <= 1'b0;
      spk_right <= 1'b0;
    end else begin
      spk_left  <= pdm_out & spk_en[0];
      spk_right <= pdm_out & spk_en[1];
    end
  end

endmodule

// ==== tb/audio_assert.sv ====
`timescale 1ns/1ps

module audio_assert (
  input logic       audio_clk,
  input logic       rst_n,
  input logic       mic_bclk,
  input logic       sample_strobe,
  input logic [1:0] spk_en,
  input logic       spk_left,
  input logic       spk_right
);

  // each bit clock level lasts 16 cycles
  bclk_steady: assert property (@(posedge audio_clk) disable iff (!rst_n)
    $changed(mic_bclk) |-> ($past(mic_bclk, 16) == $past(mic_bclk, 1)))
    else $error("mic_bclk changed before holding its level for 16 cycles");

  strobe_single: assert property (@(posedge audio_clk) disable iff (!rst_n)
    sample_strobe |=> !sample_strobe)
    else $error("sample_strobe high for two cycles in a row");

  left_gated: assert property (@(posedge audio_clk) disable iff (!rst_n)
    !spk_en[0] |=> !spk_left)
    else $error("spk_left high one cycle after its enable was low");

  right_gated: assert property (@(posedge audio_clk) disable iff (!rst_n)
    !spk_en[1] |=> !spk_right)
    else $error("spk_right high one cycle after its enable was low");

  // pins cleared by the synchronous reset
  quiet_in_reset: assert property (@(posedge audio_clk)
    !rst_n |=> (!spk_left && !spk_right))
    else $error("speaker pin high during reset");

endmodule

bind audio_top audio_assert u_assert (
  .audio_clk     (audio_clk),
  .rst_n         (rst_n),
  .mic_bclk      (mic_bclk),
  .sample_strobe (sample_strobe),
  .spk_en        (spk_en),
  .spk_left      (spk_left),
  .spk_right     (spk_right)
);

// ==== tb/audio_tb.sv ====
`timescale 1ns/1ps

module audio_tb;
  import audio_pkg::*;

  localparam int seed         = 90336;
  localparam int n_raw        = 20;
  localparam int n_dc         = 24;
  localparam int n_echo       = 24;
  localparam int echo_lag     = 12;   // delay_sel 3 at four frames per step
  localparam int n_pdm        = 34;
  localparam int pdm_tol      = 2;
  localparam int frame_cycles = 2048;
  localparam int total_frames = 2 + (n_raw + 1) + (n_dc + 1) + (n_echo + 1) + 3 * n_pdm + 6;
  localparam int timeout_cycles = total_frames * frame_cycles * 6 / 5;

  logic                   audio_clk = 1'b0;
  logic                   rst_n;
  logic                   mic_data;
  logic                   mic_bclk;
  logic                   mic_lrclk;
  logic [1:0]             source_sel;
  logic [delay_sel_w-1:0] delay_sel;
  logic [1:0]             spk_en;
  logic                   spk_left;
  logic                   spk_right;
  logic [sample_w-1:0]    monitor_sample;
  logic                   sample_strobe;

  logic signed [sample_w-1:0] mic_queue[$];  // words the microphone still has to send
  logic signed [sample_w-1:0] stim[$];       // words of the running test
  logic [sample_w-1:0]        cur_word;
  logic                       bclk_q;
  int                         bit_idx;
  int                         n_checks;
  int                         n_errors;

  audio_top u_dut (
    .audio_clk      (audio_clk),
    .rst_n          (rst_n),
    .mic_data       (mic_data),
    .mic_bclk       (mic_bclk),
    .mic_lrclk      (mic_lrclk),
    .source_sel     (source_sel),
    .delay_sel      (delay_sel),
    .spk_en         (spk_en),
    .spk_left       (spk_left),
    .spk_right      (spk_right),
    .monitor_sample (monitor_sample),
    .sample_strobe  (sample_strobe)
  );

  always #5 audio_clk = ~audio_clk;

  // microphone model shifts a new bit after each falling bclk
  // msb goes in slot 1 of the left half
  always @(posedge audio_clk) begin
    #1;
    if (bclk_q && !mic_bclk) begin
      if (mic_lrclk) begin
        bit_idx  = 0;
        mic_data = 1'b0;
      end else begin
        if (bit_idx == 1) begin
          if (mic_queue.size() > 0) begin
            cur_word = mic_queue.pop_front();
          end else begin
            cur_word = '0;
          end
        end
        if (bit_idx >= 1 && bit_idx <= sample_w) begin
          mic_data = cur_word[sample_w-bit_idx];
        end else begin
          mic_data = 1'b0;  // slot 0 and trailing slots
        end
        bit_idx++;
      end
    end
    bclk_q = mic_bclk;
  end

  task automatic check(input string name, input int expected, input int actual,
                       input int tol = 0);
    n_checks++;
    if (actual > expected + tol || actual < expected - tol) begin
      n_errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic tick();
    @(posedge audio_clk);
    #1;
  endtask

  task automatic wait_strobe(input string name);
    int n;
    n = 0;
    tick();
    while (!sample_strobe && n < 3 * frame_cycles) begin
      tick();
      n++;
    end
    if (!sample_strobe) begin
      n_errors++;
      $display("%s: no sample_strobe seen within %0d cycles", name, 3 * frame_cycles);
    end
  endtask

  task automatic restart();
    rst_n = 1'b0;
    repeat (16) tick();
    mic_queue.delete();
    bit_idx = 1;  // first falling bclk after reset opens slot 1
    rst_n   = 1'b1;
  endtask

  // rail to rail swing first and a constant tail for the filter to settle on
  task automatic load_words(input int n);
    int i;
    logic signed [sample_w-1:0] w;
    stim.delete();
    for (i = 0; i < n; i++) begin
      if (i == 0) begin
        w = 16'sh7fff;
      end else if (i == 1) begin
        w = 16'sh8000;
      end else if (i >= n - n / 4) begin
        w = 16'sd3000;
      end else begin
        w = 16'($urandom());
      end
      stim.push_back(w);
      mic_queue.push_back(w);
    end
  endtask

  // y = x - x_prev + y_prev - floor(y_prev / 256) clipped to 16 bit signed
  function automatic int dc_ref(input int x, input int x_prev, input int y_prev);
    int acc;
    acc = x - x_prev + y_prev - (y_prev >>> dc_shift);
    if (acc > 32767) begin
      acc = 32767;
    end else if (acc < -32768) begin
      acc = -32768;
    end
    return acc;
  endfunction

  task automatic count_ones(input int cycles, output int ones_l, output int ones_r);
    ones_l = 0;
    ones_r = 0;
    repeat (cycles) begin
      tick();
      ones_l += spk_left;
      ones_r += spk_right;
    end
  endtask

  task automatic test_reset_state();
    int cyc;
    int bclk_rise[$];
    int lr_edge[$];
    logic bclk_prev;
    logic lr_prev;
    restart();
    check("reset spk_left", 0, spk_left);
    check("reset spk_right", 0, spk_right);
    check("reset sample_strobe", 0, sample_strobe);
    check("reset monitor_sample", 0, monitor_sample);
    bclk_prev = mic_bclk;
    lr_prev   = mic_lrclk;
    for (cyc = 0; cyc < frame_cycles + 100; cyc++) begin
      tick();
      if (mic_bclk && !bclk_prev) begin
        bclk_rise.push_back(cyc);
      end
      if (mic_lrclk != lr_prev) begin
        lr_edge.push_back(cyc);
      end
      bclk_prev = mic_bclk;
      lr_prev   = mic_lrclk;
    end
    check("reset bclk edge count", 1, int'(bclk_rise.size() >= 2 && lr_edge.size() >= 2));
    if (bclk_rise.size() >= 2 && lr_edge.size() >= 2) begin
      check("reset bclk period", 32, bclk_rise[1] - bclk_rise[0]);
      check("reset lrclk half period", 1024, lr_edge[1] - lr_edge[0]);
    end
  endtask

  task automatic test_raw();
    int i;
    restart();
    source_sel = src_raw;
    load_words(n_raw);
    for (i = 0; i < n_raw; i++) begin
      wait_strobe("raw");
      check("raw", stim[i], $signed(monitor_sample));
    end
  endtask

  task automatic test_dc();
    int i;
    int x_prev;
    int y_prev;
    restart();
    source_sel = src_dc;
    load_words(n_dc);
    x_prev = 0;
    y_prev = 0;
    for (i = 0; i < n_dc; i++) begin
      y_prev = dc_ref(stim[i], x_prev, y_prev);
      x_prev = stim[i];
      wait_strobe("dc");
      check("dc", y_prev, $signed(monitor_sample));
    end
  endtask

  task automatic test_echo();
    int i;
    int expected;
    int dc_out[$];
    restart();
    source_sel = src_echo;
    delay_sel  = 3;
    load_words(n_echo);
    dc_out.push_back(dc_ref(stim[0], 0, 0));
    for (i = 1; i < n_echo; i++) begin
      dc_out.push_back(dc_ref(stim[i], stim[i-1], dc_out[i-1]));
    end
    for (i = 0; i < n_echo; i++) begin
      if (i == n_echo - 4) begin
        delay_sel = 0;  // last frames pass straight through
      end
      wait_strobe("echo");
      if (delay_sel == 0) begin
        expected = dc_out[i];
      end else if (i < echo_lag) begin
        expected = 0;
      end else begin
        expected = dc_out[i-echo_lag];
      end
      check("echo", expected, $signed(monitor_sample));
    end
  endtask

  task automatic test_pdm(input logic signed [sample_w-1:0] level);
    int i;
    int ones_l;
    int ones_r;
    restart();
    source_sel = src_raw;
    spk_en     = 2'b11;
    for (i = 0; i < n_pdm; i++) begin
      mic_queue.push_back(level);
    end
    wait_strobe("pdm");
    count_ones(65536, ones_l, ones_r);
    check("pdm density left", int'(level) + 32768, ones_l, pdm_tol);
    check("pdm density right", int'(level) + 32768, ones_r, pdm_tol);
  endtask

  task automatic test_mute_gating();
    int i;
    int ones_l;
    int ones_r;
    restart();
    source_sel = src_mute;
    spk_en     = 2'b01;
    load_words(4);
    for (i = 0; i < 4; i++) begin
      wait_strobe("mute");
      check("mute monitor", 0, monitor_sample);
    end
    // level 0 is half density, so 32 ones in 64 cycles
    count_ones(64, ones_l, ones_r);
    check("gating 01 left", 32, ones_l, 1);
    check("gating 01 right", 0, ones_r);
    spk_en = 2'b10;
    repeat (2) tick();
    count_ones(64, ones_l, ones_r);
    check("gating 10 left", 0, ones_l);
    check("gating 10 right", 32, ones_r, 1);
  endtask

  task automatic finish_run(input bit timed_out);
    $display("checks: %0d  errors: %0d  timeout: %0d", n_checks, n_errors, timed_out);
    if (n_errors == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(seed));
    rst_n      = 1'b0;
    mic_data   = 1'b0;
    source_sel = src_raw;
    delay_sel  = '0;
    spk_en     = 2'b00;
    bclk_q     = 1'b0;
    bit_idx    = 1;
    n_checks   = 0;
    n_errors   = 0;
    test_reset_state();
    test_raw();
    test_dc();
    test_echo();
    test_pdm(16'sh0000);
    test_pdm(16'sh4000);
    test_pdm(16'shc000);
    test_mute_gating();
    finish_run(1'b0);
  end

  // watchdog sized from the frame count of all tests
  initial begin
    repeat (timeout_cycles) @(posedge audio_clk);
    $display("watchdog: tests still running after %0d cycles, run stopped", timeout_cycles);
    finish_run(1'b1);
  end

endmodule

// ==== all.f ====
source/audio_pkg.sv
source/i2s_mic_rx.sv
source/dc_blocker.sv
source/echo_delay.sv
source/pdm_modulator.sv
source/audio_top.sv
tb/audio_assert.sv
tb/audio_tb.sv

// ==== Makefile ====
SRCS := $(shell cat all.f)

all: run

obj_dir/Vaudio_tb: all.f Makefile $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module audio_tb -f all.f -o Vaudio_tb

run: obj_dir/Vaudio_tb
	./obj_dir/Vaudio_tb > sim.log 2>&1 || echo "Result: FAILED" >> sim.log
	cat sim.log
	! grep -q "Result: FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
